// ==== common/mem_req_if.sv ====
`timescale 1ns/1ps
`include "memmgr_consts.svh"

// one requester's path to the memory arbiter
interface mem_req_if;

  // read and write levels, held until dn
  logic                  rd;
  logic                  wr;
  logic [`MM_ADDR_W-1:0] addr;
  logic [`MM_DATA_W-1:0] wdata;

  // read data valid in the dn cycle
  logic [`MM_DATA_W-1:0] rdata;
  logic                  dn;

  modport requester (
    output rd, wr, addr, wdata,
    input  rdata, dn
  );

  modport arbiter (
    input  rd, wr, addr, wdata,
    output rdata, dn
  );

endinterface

// ==== common/memmgr_consts.svh ====
`ifndef MEMMGR_CONSTS_SVH
`define MEMMGR_CONSTS_SVH

// memory address width
`define MM_ADDR_W 32

// memory data word width
`define MM_DATA_W 32

// register number field width
`define MM_REG_NUM_W 4

// operand slots, src1 src0 dst cond
`define MM_NUM_SLOTS 4

// register holding the instruction pointer
`define MM_REG_IP 15

// lane index of the dst operand
`define MM_DST_SLOT 2

`endif

// ==== common/memmgr_pkg.sv ====
`include "memmgr_consts.svh"

package memmgr_pkg;

  // post-access register update, 11 acts like 00
  typedef enum logic [1:0] {
    FLAG_NONE = 2'b00,
    FLAG_INC  = 2'b01,
    FLAG_DEC  = 2'b10,
    FLAG_KEEP = 2'b11
  } flag_mode_t;

  // one operand as handed to a slot
  typedef struct packed {
    logic [`MM_REG_NUM_W-1:0] reg_num;
    logic                     ptr;
    flag_mode_t               flags;
  } operand_field_t;

  // command word by field name
  typedef struct packed {
    logic [3:0]               cmd_code;
    flag_mode_t               cond_flags;
    flag_mode_t               dst_flags;
    flag_mode_t               src0_flags;
    flag_mode_t               src1_flags;
    logic                     cond_ptr;
    logic                     dst_ptr;
    logic                     src0_ptr;
    logic                     src1_ptr;
    logic [`MM_REG_NUM_W-1:0] cond_reg;
    logic [`MM_REG_NUM_W-1:0] dst_reg;
    logic [`MM_REG_NUM_W-1:0] src0_reg;
    logic [`MM_REG_NUM_W-1:0] src1_reg;
  } cmd_named_t;

  // same word by slot lane, lane 0 src1 up to lane 3 cond
  typedef struct packed {
    logic [3:0]                                   cmd_code;
    flag_mode_t [`MM_NUM_SLOTS-1:0]               flags;
    logic [`MM_NUM_SLOTS-1:0]                     ptr;
    logic [`MM_NUM_SLOTS-1:0][`MM_REG_NUM_W-1:0] regs;
  } cmd_lanes_t;

  typedef union packed {
    cmd_named_t named;
    cmd_lanes_t lanes;
  } cmd_word_u;

endpackage

// ==== common/slot_ctl_if.sv ====
`timescale 1ns/1ps
`include "memmgr_consts.svh"

// fetcher to one operand slot
interface slot_ctl_if;

  // one-cycle strobes from the fetcher
  logic                       go;
  logic                       store;
  memmgr_pkg::operand_field_t field;
  logic [`MM_DATA_W-1:0]      store_data;

  // done pulse, value held until next go
  logic                       done;
  logic [`MM_DATA_W-1:0]      value;

  modport fetcher (output go, store, field, store_data, input done, value);

  modport slot (input go, store, field, store_data, output done, value);

endinterface

// ==== memmgr.f ====
+incdir+common
common/memmgr_pkg.sv
common/mem_req_if.sv
common/slot_ctl_if.sv
verilog/cmd_fetcher.sv
operand_slot/operand_slot.sv
verilog/mem_arbiter.sv
verilog/mem_manager_top.sv
verification/mem_model.sv
verification/tb_mem_manager.sv

// ==== operand_slot/operand_slot.sv ====
`timescale 1ns/1ps
`include "memmgr_consts.svh"

module operand_slot (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`MM_ADDR_W-1:0] base_addr,
  slot_ctl_if.slot              ctl,
  mem_req_if.requester          mem
);

  typedef enum logic [2:0] {
    S_IDLE, S_REG_RD, S_PTR_RD, S_WB, S_ST_WR
  } state_t;

  state_t                state_q;
  logic                  rd_q;
  logic                  wr_q;
  logic                  done_q;
  logic [`MM_ADDR_W-1:0] addr_q;
  logic [`MM_ADDR_W-1:0] target_q;
  logic [`MM_ADDR_W-1:0] reg_addr;
  logic [`MM_DATA_W-1:0] wdata_q;
  logic [`MM_DATA_W-1:0] value_q;
  logic [`MM_DATA_W-1:0] reg_q;
  logic                  upd;

  // new register contents for inc or dec
  function automatic logic [`MM_DATA_W-1:0] step(
    input logic [`MM_DATA_W-1:0] v,
    input memmgr_pkg::flag_mode_t f
  );
    return (f == memmgr_pkg::FLAG_INC) ? v + `MM_DATA_W'(1) : v - `MM_DATA_W'(1);
  endfunction

  // register slot in the memory-resident file
  assign reg_addr = base_addr + `MM_ADDR_W'(ctl.field.reg_num);
  // 00 and 11 need no write-back
  assign upd = (ctl.field.flags == memmgr_pkg::FLAG_INC) ||
               (ctl.field.flags == memmgr_pkg::FLAG_DEC);

  assign mem.rd    = rd_q;
  assign mem.wr    = wr_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;
  assign ctl.done  = done_q;
  assign ctl.value = value_q;

  always_ff @(posedge clk) begin
    done_q <= 1'b0;
    if (rst) begin
      state_q <= S_IDLE;
      rd_q    <= 1'b0;
      wr_q    <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (ctl.go) begin
            addr_q  <= reg_addr;
            rd_q    <= 1'b1;
            state_q <= S_REG_RD;
          end else if (ctl.store) begin
            // store goes to whatever the last resolve left behind
            addr_q  <= target_q;
            wdata_q <= ctl.store_data;
            wr_q    <= 1'b1;
            state_q <= S_ST_WR;
          end
        end
        S_REG_RD: begin
          if (mem.dn) begin
            rd_q  <= 1'b0;
            reg_q <= mem.rdata;
            if (ctl.field.ptr) begin
              // indirect, register holds the operand address
              addr_q   <= `MM_ADDR_W'(mem.rdata);
              target_q <= `MM_ADDR_W'(mem.rdata);
              state_q  <= S_PTR_RD;
            end else begin
              value_q  <= mem.rdata;
              target_q <= addr_q;
              if (upd) begin
                wdata_q <= step(mem.rdata, ctl.field.flags);
                state_q <= S_WB;
              end else begin
                done_q  <= 1'b1;
                state_q <= S_IDLE;
              end
            end
          end
        end
        S_PTR_RD: begin
          if (mem.dn) begin
            rd_q    <= 1'b0;
            value_q <= mem.rdata;
            if (upd) begin
              // pointer register itself gets updated
              addr_q  <= reg_addr;
              wdata_q <= step(reg_q, ctl.field.flags);
              state_q <= S_WB;
            end else begin
              done_q  <= 1'b1;
              state_q <= S_IDLE;
            end
          end else begin
            rd_q <= 1'b1;
          end
        end
        S_WB, S_ST_WR: begin
          // level comes back one cycle after the previous dn
          if (mem.dn) begin
            wr_q    <= 1'b0;
            done_q  <= 1'b1;
            state_q <= S_IDLE;
          end else begin
            wr_q <= 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory manager testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mem_manager -f memmgr.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== verification/mem_model.sv ====
`timescale 1ns/1ps
`include "memmgr_consts.svh"

module mem_model #(
  parameter int IDX_W = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rd,
  input  logic                  wr,
  input  logic [`MM_ADDR_W-1:0] addr,
  input  logic [`MM_DATA_W-1:0] wdata,
  output logic [`MM_DATA_W-1:0] rdata,
  output logic                  rd_dn,
  output logic                  wr_dn,
  // backdoor write port, used only while the DUT is idle
  input  logic                  bd_we,
  input  logic [IDX_W-1:0]      bd_addr,
  input  logic [`MM_DATA_W-1:0] bd_wdata
);

  localparam int WORDS = 1 << IDX_W;

  logic [`MM_DATA_W-1:0] mem [WORDS];
  logic                  armed_q;
  logic [1:0]            wait_q;
  logic [1:0]            lat;
  logic [IDX_W-1:0]      idx;

  // upper address bits alias onto the small array
  assign idx = addr[IDX_W-1:0];

  // reset contents, every address bit changes the word
  function automatic logic [`MM_DATA_W-1:0] fill_word(input logic [IDX_W-1:0] a);
    return (32'(a) * 32'h9e37_79b9) ^ 32'hc3a5_5a3c;
  endfunction

  initial begin
    rdata = '0;
    rd_dn = 1'b0;
    wr_dn = 1'b0;
  end

  always @(posedge clk) begin
    rd_dn <= 1'b0;
    wr_dn <= 1'b0;
    if (rst) begin
      armed_q <= 1'b0;
      wait_q  <= '0;
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= fill_word(IDX_W'(i));
      end
    end else if (bd_we) begin
      mem[bd_addr] <= bd_wdata;
    end else if (rd_dn || wr_dn) begin
      // requester still shows its level in the dn cycle
      armed_q <= 1'b0;
    end else if (rd || wr) begin
      // 1 to 4 cycles from the level to dn
      lat = armed_q ? wait_q : 2'($urandom_range(0, 3));
      if (lat == 2'd0) begin
        armed_q <= 1'b0;
        if (rd) begin
          rdata <= mem[idx];
          rd_dn <= 1'b1;
        end else begin
          mem[idx] <= wdata;
          wr_dn    <= 1'b1;
        end
      end else begin
        armed_q <= 1'b1;
        wait_q  <= lat - 2'd1;
      end
    end
  end

endmodule

// ==== verification/tb_mem_manager.sv ====
`timescale 1ns/1ps
`include "memmgr_consts.svh"

module tb_mem_manager;

  localparam int MEM_WORDS = 256;
  localparam int TIMEOUT   = 200;
  localparam logic [7:0] BASE = 8'h40;

  logic                  clk;
  logic                  rst;
  logic                  fetch;
  logic                  store;
  logic [`MM_ADDR_W-1:0] base_addr;
  logic [`MM_DATA_W-1:0] dst_h;
  logic [`MM_DATA_W-1:0] mem_rdata;
  logic                  mem_rd_dn;
  logic                  mem_wr_dn;
  logic [`MM_ADDR_W-1:0] mem_addr;
  logic [`MM_DATA_W-1:0] mem_wdata;
  logic                  mem_rd;
  logic                  mem_wr;
  logic                  busy;
  logic                  operands_ready;
  logic                  store_done;
  logic [3:0]            cmd_code;
  logic [`MM_DATA_W-1:0] src1;
  logic [`MM_DATA_W-1:0] src0;
  logic [`MM_DATA_W-1:0] dst;
  logic [`MM_DATA_W-1:0] cond;
  logic                  bd_we;
  logic [7:0]            bd_addr;
  logic [`MM_DATA_W-1:0] bd_wdata;

  // expected memory contents
  logic [31:0] img [MEM_WORDS];
  // command lanes, 0 src1 1 src0 2 dst 3 cond
  logic [3:0]  lane_reg [4];
  logic        lane_ptr [4];
  logic [1:0]  lane_flag [4];
  logic [31:0] exp_val [4];
  logic [3:0]  exp_code;
  logic [7:0]  dst_target;
  int          cmd_seq;

  int checks = 0;
  int errors = 0;
  int rst_errs = 0;
  int pulse_errs = 0;
  int test_base = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int ready_cnt = 0;
  int store_cnt = 0;

  mem_manager_top mem_manager_top_i (
    .clk            (clk),
    .rst            (rst),
    .fetch          (fetch),
    .store          (store),
    .base_addr      (base_addr),
    .dst_h          (dst_h),
    .mem_rdata      (mem_rdata),
    .mem_rd_dn      (mem_rd_dn),
    .mem_wr_dn      (mem_wr_dn),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata),
    .mem_rd         (mem_rd),
    .mem_wr         (mem_wr),
    .busy           (busy),
    .operands_ready (operands_ready),
    .store_done     (store_done),
    .cmd_code       (cmd_code),
    .src1           (src1),
    .src0           (src0),
    .dst            (dst),
    .cond           (cond)
  );

  mem_model mem_model_i (
    .clk      (clk),
    .rst      (rst),
    .rd       (mem_rd),
    .wr       (mem_wr),
    .addr     (mem_addr),
    .wdata    (mem_wdata),
    .rdata    (mem_rdata),
    .rd_dn    (mem_rd_dn),
    .wr_dn    (mem_wr_dn),
    .bd_we    (bd_we),
    .bd_addr  (bd_addr),
    .bd_wdata (bd_wdata)
  );

  always #20 clk = ~clk;

  // pulse counters for the one-pulse-per-request checks
  always @(posedge clk) begin
    if (operands_ready) ready_cnt <= ready_cnt + 1;
    if (store_done) store_cnt <= store_cnt + 1;
  end

  // strobes and levels stay low in reset and the cycle after
  assert property (@(posedge clk)
    rst |=> !(mem_rd || mem_wr || busy || operands_ready || store_done))
    else begin
      $display("FAIL reset outputs rd %h wr %h busy %h ready %h store_done %h",
               mem_rd, mem_wr, busy, operands_ready, store_done);
      rst_errs++;
    end

  // completion strobes are single-cycle
  assert property (@(posedge clk) disable iff (rst)
    (operands_ready || store_done) |=> !(operands_ready || store_done))
    else begin
      $display("completion strobe stayed high for more than one cycle");
      pulse_errs++;
    end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        errors++;
      end
  endtask

  task automatic check_quiet();
    check_value("mem_rd", 32'(mem_rd), 32'd0);
    check_value("mem_wr", 32'(mem_wr), 32'd0);
    check_value("busy", 32'(busy), 32'd0);
    check_value("operands_ready", 32'(operands_ready), 32'd0);
    check_value("store_done", 32'(store_done), 32'd0);
  endtask

  task automatic compare_image();
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_value($sformatf("mem[%02h]", i), mem_model_i.mem[i], img[i]);
    end
  endtask

  // backdoor write, mirrored in img
  task automatic poke(input logic [7:0] a, input logic [31:0] d);
    @(posedge clk);
    bd_we    <= 1'b1;
    bd_addr  <= a;
    bd_wdata <= d;
    img[a] = d;
    @(posedge clk);
    bd_we <= 1'b0;
  endtask

  // sel 0 operands_ready, 1 store_done, 2 not busy
  task automatic wait_until(input int sel);
    bit hit;
    hit = 1'b0;
    for (int n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      hit = (sel == 0) ? operands_ready : (sel == 1) ? store_done : !busy;
      if (hit) break;
    end
    if (!hit) begin
      $display("timeout after %0d cycles waiting for %s", TIMEOUT,
               (sel == 0) ? "operands_ready" : (sel == 1) ? "store_done" : "idle");
      errors++;
    end
  endtask

  task automatic pulse_fetch();
    @(posedge clk);
    fetch <= 1'b1;
    @(posedge clk);
    fetch <= 1'b0;
  endtask

  task automatic pick_regs();
    logic [3:0] cand;
    bit dup;
    // distinct numbers, never the ip
    for (int i = 0; i < 4; i++) begin
      do begin
        cand = 4'($urandom_range(0, 14));
        dup  = 1'b0;
        for (int j = 0; j < i; j++) begin
          if (lane_reg[j] == cand) dup = 1'b1;
        end
      end while (dup);
      lane_reg[i] = cand;
    end
  endtask

  task automatic run_cmd(input logic [3:0] code, input bit extra);
    logic [31:0] word;
    logic [31:0] ip;
    logic [31:0] cmd;
    logic [31:0] rv;
    logic [7:0]  cmd_addr;
    logic [7:0]  ra;
    logic [1:0]  f;
    int          ready_before;
    cmd_addr = 8'hc0 + 8'(cmd_seq % 64);
    cmd_seq++;
    word = 32'(code) << 28;
    for (int i = 0; i < 4; i++) begin
      word |= 32'(lane_flag[i]) << (20 + 2 * i);
      word |= 32'(lane_ptr[i]) << (16 + i);
      word |= 32'(lane_reg[i]) << (4 * i);
    end
    poke(BASE + 8'd15, 32'(cmd_addr));
    poke(cmd_addr, word);
    for (int i = 0; i < 4; i++) begin
      if (lane_ptr[i]) begin
        // pointers land in 80..bf
        rv = 32'h80 + $urandom_range(0, 63);
        poke(BASE + 8'(lane_reg[i]), rv);
        poke(rv[7:0], $urandom);
      end else begin
        poke(BASE + 8'(lane_reg[i]), $urandom);
      end
    end
    // expected results, ip post-increment first
    ip = img[BASE + 8'd15];
    cmd = img[ip[7:0]];
    img[BASE + 8'd15] = ip + 32'd1;
    exp_code = cmd[31:28];
    for (int i = 0; i < 4; i++) begin
      ra = BASE + 8'(cmd[4 * i +: 4]);
      rv = img[ra];
      f  = cmd[20 + 2 * i +: 2];
      exp_val[i] = cmd[16 + i] ? img[rv[7:0]] : rv;
      if (i == `MM_DST_SLOT) dst_target = cmd[16 + i] ? rv[7:0] : ra;
      // value above is the pre-update one
      if (f == 2'b01) img[ra] = rv + 32'd1;
      else if (f == 2'b10) img[ra] = rv - 32'd1;
    end
    ready_before = ready_cnt;
    pulse_fetch();
    if (extra) begin
      @(negedge clk);
      check_value("busy", 32'(busy), 32'd1);
      pulse_fetch();
    end
    wait_until(0);
    check_value("src1", src1, exp_val[0]);
    check_value("src0", src0, exp_val[1]);
    check_value("dst", dst, exp_val[2]);
    check_value("cond", cond, exp_val[3]);
    check_value("cmd_code", 32'(cmd_code), 32'(exp_code));
    wait_until(2);
    // quiet window for a late second fetch
    repeat (4) @(negedge clk);
    check_value("operands_ready pulses", 32'(ready_cnt - ready_before), 32'd1);
    check_value("busy", 32'(busy), 32'd0);
    compare_image();
  endtask

  task automatic do_store(input logic [31:0] data);
    int store_before;
    store_before = store_cnt;
    @(posedge clk);
    store <= 1'b1;
    dst_h <= data;
    @(posedge clk);
    store <= 1'b0;
    wait_until(1);
    wait_until(2);
    repeat (2) @(negedge clk);
    img[dst_target] = data;
    check_value("store_done pulses", 32'(store_cnt - store_before), 32'd1);
    compare_image();
  endtask

  task automatic end_test(input string name);
    int now_errs;
    now_errs = errors + rst_errs + pulse_errs;
    tests_run++;
    if (now_errs == test_base) begin
      $display("test %-8s pass", name);
    end else begin
      tests_failed++;
      $display("test %-8s fail, %0d errors", name, now_errs - test_base);
    end
    test_base = now_errs;
  endtask

  initial begin
    void'($urandom(32'h6c79_4c32));
    clk       = 1'b0;
    rst       = 1'b1;
    fetch     = 1'b0;
    store     = 1'b0;
    base_addr = 32'(BASE);
    dst_h     = '0;
    bd_we     = 1'b0;
    bd_addr   = '0;
    bd_wdata  = '0;
    cmd_seq   = 0;

    // 1: reset, four cycles
    repeat (3) begin
      @(negedge clk);
      check_quiet();
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_quiet();
    for (int i = 0; i < MEM_WORDS; i++) begin
      img[i] = mem_model_i.mem[i];
    end
    end_test("reset");

    // 2: direct operands, no flags
    pick_regs();
    for (int i = 0; i < 4; i++) begin
      lane_ptr[i]  = 1'b0;
      lane_flag[i] = 2'b00;
    end
    run_cmd(4'ha, 1'b0);
    end_test("plain");

    // 3: all four indirect
    pick_regs();
    for (int i = 0; i < 4; i++) begin
      lane_ptr[i] = 1'b1;
    end
    run_cmd(4'h5, 1'b0);
    end_test("pointer");

    // 4: inc, dec, keep, inc with mixed indirection
    pick_regs();
    lane_flag[0] = 2'b01;
    lane_flag[1] = 2'b10;
    lane_flag[2] = 2'b11;
    lane_flag[3] = 2'b01;
    lane_ptr[0]  = 1'b1;
    lane_ptr[1]  = 1'b0;
    lane_ptr[2]  = 1'b0;
    lane_ptr[3]  = 1'b1;
    run_cmd(4'h3, 1'b0);
    end_test("flags");

    // 5: store through a pointer, then to a register
    pick_regs();
    lane_ptr[`MM_DST_SLOT] = 1'b1;
    run_cmd(4'hc, 1'b0);
    do_store($urandom);
    pick_regs();
    lane_ptr[`MM_DST_SLOT] = 1'b0;
    lane_flag[`MM_DST_SLOT] = 2'b10;
    run_cmd(4'h7, 1'b0);
    do_store($urandom);
    end_test("store");

    // 6: random commands, some with a fetch while busy
    for (int k = 0; k < 20; k++) begin
      pick_regs();
      for (int i = 0; i < 4; i++) begin
        lane_ptr[i]  = 1'($urandom_range(0, 1));
        lane_flag[i] = 2'($urandom_range(0, 3));
      end
      run_cmd(4'($urandom_range(0, 15)), (k % 4) == 1);
      if (k % 3 == 0) do_store($urandom);
    end
    end_test("random");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors + rst_errs + pulse_errs);
    if (errors + rst_errs + pulse_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/cmd_fetcher.sv ====
`timescale 1ns/1ps
`include "memmgr_consts.svh"

module cmd_fetcher (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fetch,
  input  logic                  store,
  input  logic [`MM_ADDR_W-1:0] base_addr,
  input  logic [`MM_DATA_W-1:0] dst_h,
  mem_req_if.requester          mem,
  slot_ctl_if.fetcher           slots [`MM_NUM_SLOTS],
  output logic                  busy,
  output logic                  operands_ready,
  output logic                  store_done,
  output memmgr_pkg::cmd_word_u cmd_word
);

  typedef enum logic [2:0] {
    S_IDLE, S_IP_RD, S_CMD_RD, S_IP_WR, S_OPS, S_STORE
  } state_t;

  state_t                   state_q;
  logic                     rd_q;
  logic                     wr_q;
  logic                     go_q;
  logic                     store_q;
  logic [`MM_ADDR_W-1:0]    addr_q;
  logic [`MM_DATA_W-1:0]    wdata_q;
  logic [`MM_DATA_W-1:0]    store_data_q;
  memmgr_pkg::cmd_word_u    cmd_q;
  logic [`MM_NUM_SLOTS-1:0] done_vec;
  logic [`MM_NUM_SLOTS-1:0] seen_q;
  logic [`MM_ADDR_W-1:0]    ip_addr;

  // ip lives in register 15 of the in-memory file
  assign ip_addr = base_addr + `MM_ADDR_W'(`MM_REG_IP);

  assign mem.rd    = rd_q;
  assign mem.wr    = wr_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  assign busy     = (state_q != S_IDLE);
  assign cmd_word = cmd_q;
  // last outstanding done closes the fetch
  assign operands_ready = (state_q == S_OPS) && (&(seen_q | done_vec));
  assign store_done     = (state_q == S_STORE) && done_vec[`MM_DST_SLOT];

  always_ff @(posedge clk) begin
    // strobes are single cycle
    go_q    <= 1'b0;
    store_q <= 1'b0;
    if (rst) begin
      state_q <= S_IDLE;
      rd_q    <= 1'b0;
      wr_q    <= 1'b0;
      seen_q  <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          // fetch wins over a simultaneous store
          if (fetch) begin
            addr_q  <= ip_addr;
            rd_q    <= 1'b1;
            state_q <= S_IP_RD;
          end else if (store) begin
            store_data_q <= dst_h;
            store_q      <= 1'b1;
            state_q      <= S_STORE;
          end
        end
        S_IP_RD: begin
          // ip becomes the command address, ip+1 waits for write-back
          if (mem.dn) begin
            rd_q    <= 1'b0;
            addr_q  <= `MM_ADDR_W'(mem.rdata);
            wdata_q <= mem.rdata + `MM_DATA_W'(1);
            state_q <= S_CMD_RD;
          end
        end
        S_CMD_RD: begin
          if (mem.dn) begin
            rd_q    <= 1'b0;
            cmd_q   <= mem.rdata;
            addr_q  <= ip_addr;
            state_q <= S_IP_WR;
          end else begin
            rd_q <= 1'b1;
          end
        end
        S_IP_WR: begin
          // go lands the cycle after the write-back dn
          if (mem.dn) begin
            wr_q    <= 1'b0;
            go_q    <= 1'b1;
            seen_q  <= '0;
            state_q <= S_OPS;
          end else begin
            wr_q <= 1'b1;
          end
        end
        S_OPS: begin
          // slots may finish in any order, several per cycle
          if (operands_ready) begin
            seen_q  <= '0;
            state_q <= S_IDLE;
          end else begin
            seen_q <= seen_q | done_vec;
          end
        end
        S_STORE: begin
          if (store_done) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  for (genvar i = 0; i < `MM_NUM_SLOTS; i++) begin : g_lane
    assign slots[i].go         = go_q;
    // only the dst slot takes stores
    assign slots[i].store      = store_q && (i == `MM_DST_SLOT);
    assign slots[i].store_data = store_data_q;
    assign slots[i].field      = memmgr_pkg::operand_field_t'{
      reg_num: cmd_q.lanes.regs[i],
      ptr:     cmd_q.lanes.ptr[i],
      flags:   cmd_q.lanes.flags[i]
    };
    assign done_vec[i] = slots[i].done;
  end

endmodule

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/1ps
`include "memmgr_consts.svh"

module mem_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  mem_req_if.arbiter            req [`MM_NUM_SLOTS+1],
  output logic [`MM_ADDR_W-1:0] mem_addr,
  output logic [`MM_DATA_W-1:0] mem_wdata,
  output logic                  mem_rd,
  output logic                  mem_wr,
  input  logic [`MM_DATA_W-1:0] mem_rdata,
  input  logic                  mem_rd_dn,
  input  logic                  mem_wr_dn
);

  // fetcher at 0, slots above it
  localparam int NREQ  = `MM_NUM_SLOTS + 1;
  localparam int IDX_W = $clog2(NREQ);

  logic [NREQ-1:0]       rd_vec;
  logic [NREQ-1:0]       wr_vec;
  logic [`MM_ADDR_W-1:0] addr_vec [NREQ];
  logic [`MM_DATA_W-1:0] wdata_vec [NREQ];
  logic                  locked_q;
  logic [IDX_W-1:0]      grant_q;
  logic [IDX_W-1:0]      pick;
  logic [IDX_W-1:0]      sel;
  logic                  mem_dn;

  // lowest raised index
  always_comb begin
    pick = '0;
    for (int i = NREQ - 1; i >= 0; i--) begin
      if (rd_vec[i] || wr_vec[i]) begin
        pick = IDX_W'(i);
      end
    end
  end

  // a fresh request passes through before the lock registers
  assign sel       = locked_q ? grant_q : pick;
  assign mem_dn    = mem_rd_dn | mem_wr_dn;
  assign mem_rd    = rd_vec[sel];
  assign mem_wr    = wr_vec[sel];
  assign mem_addr  = addr_vec[sel];
  assign mem_wdata = wdata_vec[sel];

  always_ff @(posedge clk) begin
    if (rst) begin
      locked_q <= 1'b0;
      grant_q  <= '0;
    end else if (mem_dn) begin
      locked_q <= 1'b0;
    end else if (!locked_q && (|(rd_vec | wr_vec))) begin
      locked_q <= 1'b1;
      grant_q  <= pick;
    end
  end

  for (genvar i = 0; i < NREQ; i++) begin : g_req
    assign rd_vec[i]    = req[i].rd;
    assign wr_vec[i]    = req[i].wr;
    assign addr_vec[i]  = req[i].addr;
    assign wdata_vec[i] = req[i].wdata;
    assign req[i].rdata = mem_rdata;
    // dn reaches the granted requester only
    assign req[i].dn    = mem_dn && (sel == IDX_W'(i));
  end

endmodule

// ==== verilog/mem_manager_top.sv ====
`timescale 1ns/1ps
`include "memmgr_consts.svh"

module mem_manager_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fetch,
  input  logic                  store,
  input  logic [`MM_ADDR_W-1:0] base_addr,
  input  logic [`MM_DATA_W-1:0] dst_h,
  input  logic [`MM_DATA_W-1:0] mem_rdata,
  input  logic                  mem_rd_dn,
  input  logic                  mem_wr_dn,
  output logic [`MM_ADDR_W-1:0] mem_addr,
  output logic [`MM_DATA_W-1:0] mem_wdata,
  output logic                  mem_rd,
  output logic                  mem_wr,
  output logic                  busy,
  output logic                  operands_ready,
  output logic                  store_done,
  output logic [3:0]            cmd_code,
  output logic [`MM_DATA_W-1:0] src1,
  output logic [`MM_DATA_W-1:0] src0,
  output logic [`MM_DATA_W-1:0] dst,
  output logic [`MM_DATA_W-1:0] cond
);

  // requester 0 is the fetcher, slot i sits at i+1
  mem_req_if  req_if [`MM_NUM_SLOTS+1] ();
  slot_ctl_if slot_if [`MM_NUM_SLOTS] ();

  memmgr_pkg::cmd_word_u cmd_word;

  cmd_fetcher cmd_fetcher_i (
    .clk            (clk),
    .rst            (rst),
    .fetch          (fetch),
    .store          (store),
    .base_addr      (base_addr),
    .dst_h          (dst_h),
    .mem            (req_if[0]),
    .slots          (slot_if),
    .busy           (busy),
    .operands_ready (operands_ready),
    .store_done     (store_done),
    .cmd_word       (cmd_word)
  );

  for (genvar i = 0; i < `MM_NUM_SLOTS; i++) begin : g_slot
    operand_slot operand_slot_i (
      .clk       (clk),
      .rst       (rst),
      .base_addr (base_addr),
      .ctl       (slot_if[i]),
      .mem       (req_if[i+1])
    );
  end

  mem_arbiter mem_arbiter_i (
    .clk       (clk),
    .rst       (rst),
    .req       (req_if),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .mem_rdata (mem_rdata),
    .mem_rd_dn (mem_rd_dn),
    .mem_wr_dn (mem_wr_dn)
  );

  // lane order src1 src0 dst cond
  assign src1     = slot_if[0].value;
  assign src0     = slot_if[1].value;
  assign dst      = slot_if[`MM_DST_SLOT].value;
  assign cond     = slot_if[3].value;
  assign cmd_code = cmd_word.named.cmd_code;

endmodule
